/* all.f */
ebi_pkg.sv
ebi_read_port.sv
ebi_write_buffer.sv
ebi_trx_seq.sv
ebi_tx.sv
ebi_rx.sv
ebi_master_bridge.sv
ebi_master_bridge_sva.sv
tb_ebi_master_bridge.sv

/* ebi_master_bridge.sv */
// top level of the cache-side bus master, ties the channel ports, sequencer and bus side together
`timescale 1ns/1ps
`default_nettype none

module ebi_master_bridge import ebi_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    // AR
    input  logic                   arvalid_i,
    input  logic [1:0]             arid_i,
    input  logic [PADDR_WIDTH-1:0] araddr_i,
    input  logic [3:0]             arsnoop_i,
    output logic                   arready_o,
    // AW
    input  logic                   awvalid_i,
    input  logic [PADDR_WIDTH-1:0] awaddr_i,
    input  logic [1:0]             awmesi_i,
    output logic                   awready_o,
    // W
    input  logic                   wvalid_i,
    input  logic [DATA_WIDTH-1:0]  wdata_i,
    output logic                   wready_o,
    // R
    input  logic                   rready_i,
    output logic                   rvalid_o,
    output logic [1:0]             rid_o,
    output logic [DATA_WIDTH-1:0]  rdata_o,
    output logic [1:0]             rmesi_o,
    // bus pins
    input  logic [EBI_WIDTH-1:0]   ebi_i,
    output logic [EBI_WIDTH-1:0]   ebi_o,
    output logic [EBI_WIDTH-1:0]   ebi_oen_o
);

    logic                   rd_pending, rd_done, resp_phase;
    logic [PADDR_WIDTH-1:0] rd_addr, wr_addr;
    logic [1:0]             rd_id, wr_mesi, resp_id, resp_mesi;
    logic [3:0]             rd_snoop;
    logic                   wr_pending, wr_done, wr_has_data;
    logic [LINE_WIDTH-1:0]  wr_line, resp_line;
    logic                   send_rd, send_wr, send_done;
    logic                   rx_wait, rx_recv, rx_start, rx_done;

    ebi_read_port i_read_port (
        .clk, .rst,
        .arvalid_i, .arid_i, .araddr_i, .arsnoop_i, .arready_o,
        .rready_i, .rvalid_o, .rid_o, .rdata_o, .rmesi_o,
        .resp_phase_i(resp_phase), .resp_id_i(resp_id), .resp_mesi_i(resp_mesi),
        .resp_line_i(resp_line),
        .rd_pending_o(rd_pending), .rd_done_o(rd_done), .rd_addr_o(rd_addr),
        .rd_id_o(rd_id), .rd_snoop_o(rd_snoop)
    );

    ebi_write_buffer i_write_buffer (
        .clk, .rst,
        .awvalid_i, .awaddr_i, .awmesi_i, .awready_o,
        .wvalid_i, .wdata_i, .wready_o,
        .wr_done_i(wr_done), .wr_pending_o(wr_pending), .wr_addr_o(wr_addr),
        .wr_mesi_o(wr_mesi), .wr_has_data_o(wr_has_data), .wr_line_o(wr_line)
    );

    ebi_trx_seq i_trx_seq (
        .clk, .rst,
        .rd_pending_i(rd_pending), .wr_pending_i(wr_pending), .send_done_i(send_done),
        .rx_start_i(rx_start), .rx_done_i(rx_done), .rd_done_i(rd_done),
        .send_rd_o(send_rd), .send_wr_o(send_wr), .rx_wait_o(rx_wait),
        .rx_recv_o(rx_recv), .resp_phase_o(resp_phase), .wr_done_o(wr_done)
    );

    ebi_tx i_tx (
        .clk, .rst,
        .send_rd_i(send_rd), .send_wr_i(send_wr),
        .rd_addr_i(rd_addr), .rd_id_i(rd_id), .rd_snoop_i(rd_snoop),
        .wr_addr_i(wr_addr), .wr_mesi_i(wr_mesi), .wr_has_data_i(wr_has_data),
        .wr_line_i(wr_line),
        .send_done_o(send_done), .ebi_o, .ebi_oen_o
    );

    ebi_rx i_rx (
        .clk, .rst,
        .ebi_i, .rx_wait_i(rx_wait), .rx_recv_i(rx_recv),
        .rx_start_o(rx_start), .rx_done_o(rx_done),
        .resp_id_o(resp_id), .resp_mesi_o(resp_mesi), .resp_line_o(resp_line)
    );

endmodule

`default_nettype wire

/* ebi_master_bridge_sva.sv */
// bus drive rules and R channel hold checks, bound into the bridge top level
`timescale 1ns/1ps
`default_nettype none

module ebi_master_bridge_sva import ebi_pkg::*; (
    input logic                  clk,
    input logic                  rst,
    input logic [EBI_WIDTH-1:0]  ebi_out_i,
    input logic [EBI_WIDTH-1:0]  ebi_oen_i,
    input logic                  rvalid_i,
    input logic                  rready_i,
    input logic [1:0]            rid_i,
    input logic [DATA_WIDTH-1:0] rdata_i,
    input logic [1:0]            rmesi_i
);

    // one enable for the whole word
    oen_uniform: assert property (@(posedge clk) disable iff (rst)
        (ebi_oen_i == '0) || (ebi_oen_i == '1))
        else $error("ebi_oen_o bits are not all equal");

    idle_when_released: assert property (@(posedge clk) disable iff (rst)
        (ebi_oen_i == '1) |-> (ebi_out_i == IDLE_WORD))
        else $error("ebi_o is not the idle word while the bus is released");

    r_hold: assert property (@(posedge clk) disable iff (rst)
        (rvalid_i && !rready_i) |=>
            (rvalid_i && $stable(rdata_i) && $stable(rid_i) && $stable(rmesi_i)))
        else $error("R channel changed while waiting for rready");

endmodule

bind ebi_master_bridge ebi_master_bridge_sva i_sva (
    .clk(clk), .rst(rst),
    .ebi_out_i(ebi_o), .ebi_oen_i(ebi_oen_o),
    .rvalid_i(rvalid_o), .rready_i(rready_i),
    .rid_i(rid_o), .rdata_i(rdata_o), .rmesi_i(rmesi_o)
);

`default_nettype wire

/* ebi_pkg.sv */
// shared widths, frame word counts, bus opcodes and sequencer states, imported by all bridge rtl
`default_nettype none

package ebi_pkg;

    // widths
    localparam int EBI_WIDTH      = 16;
    localparam int PADDR_WIDTH    = 32;
    localparam int DATA_WIDTH     = 64;
    localparam int LINE_WIDTH     = 512;
    localparam int OPCODE_WIDTH   = 4;

    // counts
    localparam int LINE_BEATS     = 8;
    localparam int LINE_WORDS     = 32;
    localparam int RD_REQ_WORDS   = 5;   // opcode, addr lo, addr hi, id, snoop
    localparam int WR_HDR_WORDS   = 4;   // opcode, addr lo, addr hi, mesi
    localparam int WR_DATA_WORDS  = WR_HDR_WORDS + LINE_WORDS;
    localparam int RESP_HDR_WORDS = 3;   // opcode, id, mesi
    localparam int RD_RESP_WORDS  = RESP_HDR_WORDS + LINE_WORDS;

    // counter widths
    localparam int BEAT_CNT_WIDTH = 3;   // beat index in a line
    localparam int WORD_IDX_WIDTH = 5;   // data word index in a line
    localparam int WORD_CNT_WIDTH = 6;   // word index in a frame

    // opcodes in the low nibble of a bus word
    localparam logic [OPCODE_WIDTH-1:0] OP_DR        = 4'd0;
    localparam logic [OPCODE_WIDTH-1:0] OP_DW_DATA   = 4'd1;
    localparam logic [OPCODE_WIDTH-1:0] OP_DW_NODATA = 4'd2;
    localparam logic [OPCODE_WIDTH-1:0] OP_IDLE      = 4'd5;
    localparam logic [OPCODE_WIDTH-1:0] OP_RD_RESP   = 4'd7;
    localparam logic [OPCODE_WIDTH-1:0] OP_ACK       = 4'd15;

    // both sides put this on the bus when not sending
    localparam logic [EBI_WIDTH-1:0] IDLE_WORD = {{(EBI_WIDTH-OPCODE_WIDTH){1'b0}}, OP_IDLE};

    localparam logic [1:0] MESI_M = 2'b11;

    typedef enum logic [2:0] {
        IDLE,
        SEND_AR,
        WAIT_R,
        RECV_R,
        RESP_R,
        SEND_W,
        WAIT_WACK,
        CHECK_WACK
    } trx_state_t;

endpackage

`default_nettype wire

/* ebi_read_port.sv */
// read side of the bridge: holds one AR request and streams the received line out on R
`timescale 1ns/1ps
`default_nettype none

module ebi_read_port import ebi_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    // AR channel
    input  logic                   arvalid_i,
    input  logic [1:0]             arid_i,
    input  logic [PADDR_WIDTH-1:0] araddr_i,
    input  logic [3:0]             arsnoop_i,
    output logic                   arready_o,
    // R channel
    input  logic                   rready_i,
    output logic                   rvalid_o,
    output logic [1:0]             rid_o,
    output logic [DATA_WIDTH-1:0]  rdata_o,
    output logic [1:0]             rmesi_o,
    // from sequencer and receiver
    input  logic                   resp_phase_i,
    input  logic [1:0]             resp_id_i,
    input  logic [1:0]             resp_mesi_i,
    input  logic [LINE_WIDTH-1:0]  resp_line_i,
    // to sequencer and transmitter
    output logic                   rd_pending_o,
    output logic                   rd_done_o,
    output logic [PADDR_WIDTH-1:0] rd_addr_o,
    output logic [1:0]             rd_id_o,
    output logic [3:0]             rd_snoop_o
);

    logic [BEAT_CNT_WIDTH-1:0] beat;
    logic                      ar_hs;
    logic                      r_hs;

    assign arready_o = !rd_pending_o;   // one request in flight
    assign ar_hs     = arvalid_i && arready_o;
    assign r_hs      = rvalid_o && rready_i;
    assign rd_done_o = r_hs && (beat == BEAT_CNT_WIDTH'(LINE_BEATS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pending_o <= 1'b0;
        end else if (ar_hs) begin
            rd_pending_o <= 1'b1;
        end else if (rd_done_o) begin
            rd_pending_o <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rd_addr_o  <= araddr_i;
            rd_id_o    <= arid_i;
            rd_snoop_o <= arsnoop_i;
        end
    end

    // beat index steps only on a taken beat
    always_ff @(posedge clk) begin
        if (rst || rd_done_o) begin
            beat <= '0;
        end else if (r_hs) begin
            beat <= beat + 1'b1;
        end
    end

    assign rvalid_o = resp_phase_i;
    assign rid_o    = resp_id_i;
    assign rmesi_o  = resp_mesi_i;
    assign rdata_o  = resp_line_i[beat*DATA_WIDTH +: DATA_WIDTH];   // lowest beat first

endmodule

`default_nettype wire

/* ebi_rx.sv */
// bus receiver: spots a frame start against the idle word and collects the read response
`timescale 1ns/1ps
`default_nettype none

module ebi_rx import ebi_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [EBI_WIDTH-1:0]  ebi_i,
    input  logic                  rx_wait_i,
    input  logic                  rx_recv_i,
    output logic                  rx_start_o,
    output logic                  rx_done_o,
    output logic [1:0]            resp_id_o,
    output logic [1:0]            resp_mesi_o,
    output logic [LINE_WIDTH-1:0] resp_line_o
);

    logic [OPCODE_WIDTH-1:0]   resp_op;
    logic [WORD_CNT_WIDTH-1:0] cnt;        // words taken after the opcode
    logic [WORD_IDX_WIDTH-1:0] data_idx;
    logic                      store;

    assign rx_start_o = rx_wait_i && (ebi_i != IDLE_WORD);
    assign rx_done_o  = rx_recv_i && (cnt == WORD_CNT_WIDTH'(RD_RESP_WORDS - 2));

    // data starts after the three header words (frame position is cnt + 1)
    assign data_idx = WORD_IDX_WIDTH'(cnt + 1'b1 - WORD_CNT_WIDTH'(RESP_HDR_WORDS));
    assign store    = rx_recv_i && (resp_op == OP_RD_RESP);

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_op <= OP_IDLE;
        end else if (rx_start_o) begin
            resp_op <= ebi_i[OPCODE_WIDTH-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst || !rx_recv_i || rx_done_o) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (store) begin
            case (cnt)
                6'd0:    resp_id_o   <= ebi_i[1:0];
                6'd1:    resp_mesi_o <= ebi_i[1:0];
                default: resp_line_o[data_idx*EBI_WIDTH +: EBI_WIDTH] <= ebi_i;
            endcase
        end
    end

endmodule

`default_nettype wire

/* ebi_trx_seq.sv */
// transaction sequencer: runs one read or one write exchange at a time, reads first
`timescale 1ns/1ps
`default_nettype none

module ebi_trx_seq import ebi_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic rd_pending_i,
    input  logic wr_pending_i,
    input  logic send_done_i,
    input  logic rx_start_i,
    input  logic rx_done_i,
    input  logic rd_done_i,
    output logic send_rd_o,
    output logic send_wr_o,
    output logic rx_wait_o,
    output logic rx_recv_o,
    output logic resp_phase_o,
    output logic wr_done_o
);

    trx_state_t state;
    trx_state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (rd_pending_i) begin
                    state_nxt = SEND_AR;
                end else if (wr_pending_i) begin
                    state_nxt = SEND_W;
                end
            end
            SEND_AR: begin
                if (send_done_i) begin
                    state_nxt = WAIT_R;
                end
            end
            WAIT_R: begin
                if (rx_start_i) begin
                    state_nxt = RECV_R;
                end
            end
            RECV_R: begin
                if (rx_done_i) begin
                    state_nxt = RESP_R;
                end
            end
            RESP_R: begin
                if (rd_done_i) begin
                    state_nxt = IDLE;   // last beat taken by the cache
                end
            end
            SEND_W: begin
                if (send_done_i) begin
                    state_nxt = WAIT_WACK;
                end
            end
            WAIT_WACK: begin
                if (rx_start_i) begin
                    state_nxt = CHECK_WACK;   // ack is a single word
                end
            end
            CHECK_WACK: state_nxt = IDLE;
            default:    state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // state decode
    assign send_rd_o    = (state == SEND_AR);
    assign send_wr_o    = (state == SEND_W);
    assign rx_wait_o    = (state == WAIT_R) || (state == WAIT_WACK);
    assign rx_recv_o    = (state == RECV_R);
    assign resp_phase_o = (state == RESP_R);
    assign wr_done_o    = (state == CHECK_WACK);   // frees the write buffer

endmodule

`default_nettype wire

/* ebi_tx.sv */
// bus transmitter: serializes read and write request frames and drives the output enable
`timescale 1ns/1ps
`default_nettype none

module ebi_tx import ebi_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   send_rd_i,
    input  logic                   send_wr_i,
    input  logic [PADDR_WIDTH-1:0] rd_addr_i,
    input  logic [1:0]             rd_id_i,
    input  logic [3:0]             rd_snoop_i,
    input  logic [PADDR_WIDTH-1:0] wr_addr_i,
    input  logic [1:0]             wr_mesi_i,
    input  logic                   wr_has_data_i,
    input  logic [LINE_WIDTH-1:0]  wr_line_i,
    output logic                   send_done_o,
    output logic [EBI_WIDTH-1:0]   ebi_o,
    output logic [EBI_WIDTH-1:0]   ebi_oen_o
);

    logic [WORD_CNT_WIDTH-1:0] cnt;
    logic [WORD_CNT_WIDTH-1:0] frame_len;
    logic [WORD_IDX_WIDTH-1:0] data_idx;
    logic [EBI_WIDTH-1:0]      word;
    logic [OPCODE_WIDTH-1:0]   wr_op;
    logic                      sending;

    assign sending   = send_rd_i || send_wr_i;
    assign wr_op     = wr_has_data_i ? OP_DW_DATA : OP_DW_NODATA;
    assign data_idx  = WORD_IDX_WIDTH'(cnt - WORD_CNT_WIDTH'(WR_HDR_WORDS));
    assign frame_len = send_rd_i     ? WORD_CNT_WIDTH'(RD_REQ_WORDS) :
                       wr_has_data_i ? WORD_CNT_WIDTH'(WR_DATA_WORDS) :
                                       WORD_CNT_WIDTH'(WR_HDR_WORDS);
    assign send_done_o = sending && (cnt == frame_len - 1'b1);

    always_ff @(posedge clk) begin
        if (rst || !sending || send_done_o) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    always_comb begin
        word = IDLE_WORD;
        if (send_rd_i) begin
            case (cnt)
                6'd0:    word = {{(EBI_WIDTH-OPCODE_WIDTH){1'b0}}, OP_DR};
                6'd1:    word = rd_addr_i[EBI_WIDTH-1:0];   // address low half first
                6'd2:    word = rd_addr_i[PADDR_WIDTH-1:EBI_WIDTH];
                6'd3:    word = {{(EBI_WIDTH-2){1'b0}}, rd_id_i};
                6'd4:    word = {{(EBI_WIDTH-4){1'b0}}, rd_snoop_i};
                default: word = IDLE_WORD;
            endcase
        end else if (send_wr_i) begin
            case (cnt)
                6'd0:    word = {{(EBI_WIDTH-OPCODE_WIDTH){1'b0}}, wr_op};
                6'd1:    word = wr_addr_i[EBI_WIDTH-1:0];
                6'd2:    word = wr_addr_i[PADDR_WIDTH-1:EBI_WIDTH];
                6'd3:    word = {{(EBI_WIDTH-2){1'b0}}, wr_mesi_i};
                default: word = wr_line_i[data_idx*EBI_WIDTH +: EBI_WIDTH];   // line data
            endcase
        end
    end

    assign ebi_o     = sending ? word : IDLE_WORD;
    assign ebi_oen_o = {EBI_WIDTH{!sending}};   // low while driving

endmodule

`default_nettype wire

/* ebi_write_buffer.sv */
// write side of the bridge: takes an AW request, fills the line from W beats for a modified line
`timescale 1ns/1ps
`default_nettype none

module ebi_write_buffer import ebi_pkg::*; (
    input  logic                   clk,
    input  logic                   rst,
    // AW channel
    input  logic                   awvalid_i,
    input  logic [PADDR_WIDTH-1:0] awaddr_i,
    input  logic [1:0]             awmesi_i,
    output logic                   awready_o,
    // W channel
    input  logic                   wvalid_i,
    input  logic [DATA_WIDTH-1:0]  wdata_i,
    output logic                   wready_o,
    // sequencer and transmitter side
    input  logic                   wr_done_i,
    output logic                   wr_pending_o,
    output logic [PADDR_WIDTH-1:0] wr_addr_o,
    output logic [1:0]             wr_mesi_o,
    output logic                   wr_has_data_o,
    output logic [LINE_WIDTH-1:0]  wr_line_o
);

    logic [BEAT_CNT_WIDTH-1:0] beat;
    logic                      filling;
    logic                      aw_hs;
    logic                      w_hs;
    logic                      last_beat;

    assign awready_o = !filling && !wr_pending_o;
    assign wready_o  = filling;
    assign aw_hs     = awvalid_i && awready_o;
    assign w_hs      = wvalid_i && wready_o;
    assign last_beat = w_hs && (beat == BEAT_CNT_WIDTH'(LINE_BEATS - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            filling       <= 1'b0;
            wr_pending_o  <= 1'b0;
            wr_has_data_o <= 1'b0;
            beat          <= '0;
        end else begin
            if (aw_hs) begin
                beat <= '0;
                if (awmesi_i == MESI_M) begin
                    filling       <= 1'b1;   // dirty line with data on W
                    wr_has_data_o <= 1'b1;
                end else begin
                    wr_pending_o  <= 1'b1;   // header only frame
                    wr_has_data_o <= 1'b0;
                end
            end else if (w_hs) begin
                beat <= beat + 1'b1;
                if (last_beat) begin
                    filling      <= 1'b0;
                    wr_pending_o <= 1'b1;
                end
            end else if (wr_done_i) begin
                wr_pending_o <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            wr_addr_o <= awaddr_i;
            wr_mesi_o <= awmesi_i;
        end
        if (w_hs) begin
            wr_line_o[beat*DATA_WIDTH +: DATA_WIDTH] <= wdata_i;
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# build the bridge testbench with Verilator, run it and scan the log for a failure
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --timing --timescale 1ns/1ps \
    --top-module tb_ebi_master_bridge -f all.f -o tb_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* FAILED \*\*\*' sim.log; then
    exit 1
fi
exit 0

/* tb_ebi_master_bridge.sv */
// directed testbench for the bus bridge master, with a bus peer model that answers each frame
`timescale 1ns/1ps
`default_nettype none

module tb_ebi_master_bridge import ebi_pkg::*; ();

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int NUM_TESTS    = 6;
    localparam int TEST_CYCLES  = 400;   // budget per test
    localparam int SEED         = 7945;

    logic        clk = 1'b0;
    logic        rst;
    logic        arvalid, arready, awvalid, awready, wvalid, wready, rready, rvalid;
    logic [1:0]  arid, awmesi, rid, rmesi;
    logic [31:0] araddr, awaddr;
    logic [3:0]  arsnoop;
    logic [63:0] wdata, rdata;
    logic [15:0] ebi_in, ebi_out, ebi_oen;

    int          errors;
    int          tests_run;
    int          tests_failed;
    logic        wready_seen;
    logic [15:0] frame_q[$];              // words seen from the DUT
    logic [15:0] reply_q[$];              // words the peer sends back
    logic [15:0] line_words[LINE_WORDS];  // line held by the peer
    logic [63:0] wr_beats[LINE_BEATS];

    ebi_master_bridge i_dut (
        .clk(clk), .rst(rst),
        .arvalid_i(arvalid), .arid_i(arid), .araddr_i(araddr), .arsnoop_i(arsnoop),
        .arready_o(arready),
        .awvalid_i(awvalid), .awaddr_i(awaddr), .awmesi_i(awmesi), .awready_o(awready),
        .wvalid_i(wvalid), .wdata_i(wdata), .wready_o(wready),
        .rready_i(rready), .rvalid_o(rvalid), .rid_o(rid), .rdata_o(rdata), .rmesi_o(rmesi),
        .ebi_i(ebi_in), .ebi_o(ebi_out), .ebi_oen_o(ebi_oen)
    );

    always #(CLK_PERIOD/2) clk = ~clk;

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
            errors++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (errors == errors_before) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d check errors", name, errors - errors_before);
            tests_failed++;
        end
    endtask

    // beat b of the peer line with its lowest word in the low bits
    function automatic logic [63:0] line_beat(input int b);
        return {line_words[4*b+3], line_words[4*b+2], line_words[4*b+1], line_words[4*b]};
    endfunction

    task automatic ar_request(input logic [1:0] id, input logic [31:0] addr,
                              input logic [3:0] snoop);
        arvalid <= 1'b1;
        arid    <= id;
        araddr  <= addr;
        arsnoop <= snoop;
        do @(posedge clk); while (!arready);
        arvalid <= 1'b0;
    endtask

    task automatic aw_request(input logic [31:0] addr, input logic [1:0] mesi);
        awvalid <= 1'b1;
        awaddr  <= addr;
        awmesi  <= mesi;
        do @(posedge clk); while (!awready);
        awvalid <= 1'b0;
    endtask

    task automatic w_stream();
        for (int b = 0; b < LINE_BEATS; b++) begin
            wvalid <= 1'b1;
            wdata  <= wr_beats[b];
            do @(posedge clk); while (!wready);
        end
        wvalid <= 1'b0;
    endtask

    // peer side takes every word while the DUT drives the bus
    task automatic collect_frame();
        frame_q.delete();
        forever begin
            @(posedge clk);
            wready_seen = wready_seen | wready;
            if (ebi_oen[0] == 1'b0) begin
                frame_q.push_back(ebi_out);
            end else if (frame_q.size() > 0) begin
                break;
            end
        end
    endtask

    task automatic drive_frame();
        int gap;
        gap = int'($urandom % 4);   // idle words before the reply
        repeat (gap) @(posedge clk);
        foreach (reply_q[k]) begin
            ebi_in <= reply_q[k];
            @(posedge clk);
        end
        ebi_in <= IDLE_WORD;
    endtask

    task automatic answer_read(input logic [1:0] id, input logic [1:0] mesi);
        reply_q.delete();
        reply_q.push_back({12'h000, OP_RD_RESP});
        reply_q.push_back({14'h0000, id});
        reply_q.push_back({14'h0000, mesi});
        foreach (line_words[k]) reply_q.push_back(line_words[k]);
        drive_frame();
    endtask

    task automatic acknowledge_write();
        int n;
        reply_q.delete();
        reply_q.push_back({12'h000, OP_ACK});
        drive_frame();
        check_val("awready before ack", 64'(awready), 64'(0));
        n = 0;
        while (!awready && n < 4) begin
            @(posedge clk);
            n++;
        end
        check_val("awready after ack", 64'(awready), 64'(1));
    endtask

    task automatic recv_beats(input logic [1:0] id, input logic [1:0] mesi, input bit gaps);
        int beat;
        beat = 0;
        while (beat < LINE_BEATS) begin
            rready <= gaps ? (($urandom % 2) == 0) : 1'b1;
            @(posedge clk);
            check_val("arready", 64'(arready), 64'(0));   // still busy with this read
            if (rvalid && rready) begin
                check_val($sformatf("rdata beat %0d", beat), rdata, line_beat(beat));
                check_val("rid", 64'(rid), 64'(id));
                check_val("rmesi", 64'(rmesi), 64'(mesi));
                beat++;
            end
        end
        rready <= 1'b0;
    endtask

    task automatic check_read_frame(input logic [1:0] id, input logic [31:0] addr,
                                    input logic [3:0] snoop);
        check_val("read frame length", 64'(frame_q.size()), 64'(5));
        if (frame_q.size() == 5) begin
            check_val("ebi_o opcode", 64'(frame_q[0]), 64'(OP_DR));
            check_val("ebi_o addr lo", 64'(frame_q[1]), 64'(addr[15:0]));
            check_val("ebi_o addr hi", 64'(frame_q[2]), 64'(addr[31:16]));
            check_val("ebi_o id", 64'(frame_q[3]), 64'(id));
            check_val("ebi_o snoop", 64'(frame_q[4]), 64'(snoop));
        end
    endtask

    task automatic check_write_frame(input logic [31:0] addr, input logic [1:0] mesi,
                                     input bit has_data);
        int n;
        n = has_data ? 36 : 4;
        check_val("write frame length", 64'(frame_q.size()), 64'(n));
        if (frame_q.size() == n) begin
            check_val("ebi_o opcode", 64'(frame_q[0]),
                      has_data ? 64'(OP_DW_DATA) : 64'(OP_DW_NODATA));
            check_val("ebi_o addr lo", 64'(frame_q[1]), 64'(addr[15:0]));
            check_val("ebi_o addr hi", 64'(frame_q[2]), 64'(addr[31:16]));
            check_val("ebi_o mesi", 64'(frame_q[3]), 64'(mesi));
            for (int k = 0; k < n - 4; k++) begin
                check_val($sformatf("ebi_o data %0d", k), 64'(frame_q[4+k]),
                          64'(wr_beats[k/4][(k%4)*16 +: 16]));
            end
        end
    endtask

    task automatic fill_data();
        foreach (line_words[k]) line_words[k] = 16'($urandom);
        foreach (wr_beats[b]) wr_beats[b] = {$urandom, $urandom};
    endtask

    task automatic reset_values();
        int start;
        start = errors;
        @(posedge clk);
        check_val("arready", 64'(arready), 64'(1));
        check_val("awready", 64'(awready), 64'(1));
        check_val("wready", 64'(wready), 64'(0));
        check_val("rvalid", 64'(rvalid), 64'(0));
        check_val("ebi_oen_o", 64'(ebi_oen), 64'(16'hffff));
        check_val("ebi_o", 64'(ebi_out), 64'(IDLE_WORD));
        finish_test("reset values", start);
    endtask

    task automatic read_line(input string name, input bit gaps);
        int          start;
        logic [31:0] addr;
        logic [1:0]  id, peer_id, peer_mesi;
        logic [3:0]  snoop;
        start     = errors;
        addr      = $urandom;
        id        = 2'($urandom);
        snoop     = 4'($urandom);
        peer_id   = 2'($urandom);
        peer_mesi = 2'($urandom);
        fill_data();
        ar_request(id, addr, snoop);
        collect_frame();
        check_read_frame(id, addr, snoop);
        answer_read(peer_id, peer_mesi);
        recv_beats(peer_id, peer_mesi, gaps);
        @(posedge clk);
        check_val("arready after last beat", 64'(arready), 64'(1));
        finish_test(name, start);
    endtask

    task automatic write_line(input string name, input logic [1:0] mesi);
        int          start;
        logic [31:0] addr;
        start       = errors;
        addr        = $urandom;
        wready_seen = 1'b0;
        fill_data();
        aw_request(addr, mesi);
        if (mesi == MESI_M) w_stream();
        collect_frame();
        check_val("awready while pending", 64'(awready), 64'(0));
        check_write_frame(addr, mesi, mesi == MESI_M);
        if (mesi != MESI_M) check_val("wready seen", 64'(wready_seen), 64'(0));
        acknowledge_write();
        finish_test(name, start);
    endtask

    task automatic read_before_write();
        int          start;
        logic [31:0] rd_addr, wr_addr;
        logic [1:0]  wr_mesi;
        start   = errors;
        rd_addr = $urandom;
        wr_addr = $urandom;
        wr_mesi = 2'($urandom % 3);   // clean line without W beats
        fill_data();
        arvalid <= 1'b1;
        arid    <= 2'd2;
        araddr  <= rd_addr;
        arsnoop <= 4'h3;
        awvalid <= 1'b1;
        awaddr  <= wr_addr;
        awmesi  <= wr_mesi;
        @(posedge clk);
        check_val("arready", 64'(arready), 64'(1));
        check_val("awready", 64'(awready), 64'(1));
        arvalid <= 1'b0;
        awvalid <= 1'b0;
        collect_frame();
        check_read_frame(2'd2, rd_addr, 4'h3);
        answer_read(2'd1, 2'd2);
        recv_beats(2'd1, 2'd2, 1'b0);
        collect_frame();   // write goes out only now
        check_write_frame(wr_addr, wr_mesi, 1'b0);
        acknowledge_write();
        finish_test("read before write", start);
    endtask

    initial begin
        #(TEST_CYCLES * NUM_TESTS * CLK_PERIOD);
        $display("timeout: tests did not complete within %0d cycles", TEST_CYCLES * NUM_TESTS);
        $display("*** FAILED ***");
        $finish;
    end

    initial begin
        void'($urandom(SEED));
        rst          = 1'b1;
        arvalid      = 1'b0;
        arid         = '0;
        araddr       = '0;
        arsnoop      = '0;
        awvalid      = 1'b0;
        awaddr       = '0;
        awmesi       = '0;
        wvalid       = 1'b0;
        wdata        = '0;
        rready       = 1'b0;
        ebi_in       = IDLE_WORD;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        wready_seen  = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        reset_values();
        read_line("read", 1'b0);
        read_line("read with rready gaps", 1'b1);
        write_line("modified write", MESI_M);
        write_line("clean write", 2'd1);
        read_before_write();

        $display("summary: %0d tests, %0d failing, %0d check errors",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
